// File: source/glb_pkg.sv
////////////////////
// shared widths, request field positions and register map of the global block
// request bits 62:56 (privilege, byte enables, level) are not decoded
// source order fixes the done-bit layout: unit u owns bits 2u and 2u+1
////////////////////
package glb_pkg;

  ////////////////////
  // bus widths
  localparam int REQ_PD_W  = 63;
  localparam int RESP_PD_W = 34;
  localparam int DATA_W    = 32;
  localparam int OFFSET_W  = 12;
  localparam int NUM_DONE  = 16;  // 8 units x 2 groups

  ////////////////////
  // request packet fields
  localparam int REQ_ADDR_LSB    = 0;   // 22-bit word address
  localparam int REQ_WDAT_LSB    = 22;  // 32-bit write data
  localparam int REQ_WRITE_BIT   = 54;
  localparam int REQ_NPOSTED_BIT = 55;

  // response packet fields
  localparam int RESP_KIND_BIT = 33;  // 0 read, 1 write
  localparam int RESP_ERR_BIT  = 32;

  ////////////////////
  // register byte offsets
  localparam logic [OFFSET_W-1:0] OFS_HW_VERSION  = 12'h000;
  localparam logic [OFFSET_W-1:0] OFS_INTR_MASK   = 12'h004;
  localparam logic [OFFSET_W-1:0] OFS_INTR_SET    = 12'h008;  // write only
  localparam logic [OFFSET_W-1:0] OFS_INTR_STATUS = 12'h00C;  // write one to clear

  // done source units
  localparam logic [2:0] SRC_BDMA     = 3'd0;
  localparam logic [2:0] SRC_CDP      = 3'd1;
  localparam logic [2:0] SRC_PDP      = 3'd2;
  localparam logic [2:0] SRC_SDP      = 3'd3;
  localparam logic [2:0] SRC_RUBIK    = 3'd4;
  localparam logic [2:0] SRC_CDMA_DAT = 3'd5;
  localparam logic [2:0] SRC_CDMA_WT  = 3'd6;
  localparam logic [2:0] SRC_CACC     = 3'd7;  // highest index

endpackage

// File: source/glb_reg_if.sv
////////////////////
// register bus between the csb front end and the register file
// read data is combinational from the offset, no handshake
// write enable is a one-cycle level per captured write
////////////////////
interface glb_reg_if import glb_pkg::*; ();

  logic [OFFSET_W-1:0] reg_offset;   // byte offset, word aligned
  logic                reg_wr_en;
  logic [DATA_W-1:0]   reg_wr_data;
  logic [DATA_W-1:0]   reg_rd_data;

  modport csb (
    output reg_offset,
    output reg_wr_en,
    output reg_wr_data,
    input  reg_rd_data
  );

  modport regs (
    input  reg_offset,
    input  reg_wr_en,
    input  reg_wr_data,
    output reg_rd_data
  );

endinterface

// File: source/glb_intr_if.sv
////////////////////
// interrupt control between the register file and the collector
// sw_set and sw_clr are single-cycle pulses, mask is a level
////////////////////
interface glb_intr_if import glb_pkg::*; ();

  logic [NUM_DONE-1:0] sw_set;   // write one to set
  logic [NUM_DONE-1:0] sw_clr;   // write one to clear
  logic [NUM_DONE-1:0] mask;     // 1 blocks the source
  logic [NUM_DONE-1:0] status;   // sticky done bits

  modport regs (
    output sw_set,
    output sw_clr,
    output mask,
    input  status
  );

  modport ic (
    input  sw_set,
    input  sw_clr,
    input  mask,
    output status
  );

endinterface

// File: source/glb_csb.sv
////////////////////
// csb front end, captures one request per cycle, no back-pressure
// response comes one cycle after capture, posted writes get none
// error bit of every response is zero
////////////////////
module glb_csb import glb_pkg::*; (
  input  logic                 nvdla_core_clk,
  input  logic                 nvdla_core_rstn,
  input  logic                 csb2glb_req_pvld,
  input  logic [REQ_PD_W-1:0]  csb2glb_req_pd,
  output logic                 csb2glb_req_prdy,
  output logic                 glb2csb_resp_valid,
  output logic [RESP_PD_W-1:0] glb2csb_resp_pd,
  glb_reg_if.csb               reg_bus
);

  localparam int ADDR_W = REQ_WDAT_LSB - REQ_ADDR_LSB;  // word address bits

  logic                 req_vld;
  logic [REQ_PD_W-1:0]  req_pd;
  logic [ADDR_W-1:0]    req_addr;
  logic                 req_write;
  logic                 req_nposted;
  logic [DATA_W-1:0]    req_wdat;
  logic                 rsp_rd_vld;
  logic                 rsp_wr_vld;
  logic                 rsp_vld;
  logic [RESP_PD_W-1:0] rsp_pd;

  ////////////////////
  // request capture

  assign csb2glb_req_prdy = 1'b1;  // always ready

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      req_vld <= 1'b0;
    end else begin
      req_vld <= csb2glb_req_pvld;
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (csb2glb_req_pvld) begin
      req_pd <= csb2glb_req_pd;  // payload, held when idle
    end
  end

  assign req_addr    = req_pd[REQ_ADDR_LSB +: ADDR_W];
  assign req_wdat    = req_pd[REQ_WDAT_LSB +: DATA_W];
  assign req_write   = req_pd[REQ_WRITE_BIT];
  assign req_nposted = req_pd[REQ_NPOSTED_BIT];

  // register bus, word address to byte offset
  assign reg_bus.reg_offset  = {req_addr[OFFSET_W-3:0], 2'b00};
  assign reg_bus.reg_wr_en   = req_vld & req_write;
  assign reg_bus.reg_wr_data = req_wdat;

  ////////////////////
  // response

  assign rsp_rd_vld = req_vld & ~req_write;
  assign rsp_wr_vld = req_vld & req_write & req_nposted;
  assign rsp_vld    = rsp_rd_vld | rsp_wr_vld;

  always_comb begin
    rsp_pd                = '0;
    rsp_pd[RESP_KIND_BIT] = rsp_wr_vld;  // write response kind
    rsp_pd[RESP_ERR_BIT]  = 1'b0;        // no error reporting
    if (rsp_rd_vld) begin
      rsp_pd[DATA_W-1:0] = reg_bus.reg_rd_data;
    end
  end

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      glb2csb_resp_valid <= 1'b0;
    end else begin
      glb2csb_resp_valid <= rsp_vld;
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (rsp_vld) begin
      glb2csb_resp_pd <= rsp_pd;
    end
  end

  // a response always traces back to a capture one cycle earlier
  a_resp_after_req: assert property (
    @(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    glb2csb_resp_valid |-> $past(req_vld)
  );

endmodule

// File: source/glb_csb_reg.sv
////////////////////
// global register file, four registers at offsets 0x000 to 0x00c
// intr_set is write only and reads zero, status is write one to clear
// unmapped offsets read zero and ignore writes
////////////////////
module glb_csb_reg import glb_pkg::*; #(
  parameter logic [31:0] HW_VERSION = 32'h0001_0001
) (
  input  logic      nvdla_core_clk,
  input  logic      nvdla_core_rstn,
  glb_reg_if.regs   reg_bus,
  glb_intr_if.regs  intr
);

  logic                sel_mask;
  logic                sel_set;
  logic                sel_status;
  logic                wr_mask;
  logic                wr_set;
  logic                wr_status;
  logic [NUM_DONE-1:0] intr_mask;
  logic [NUM_DONE-1:0] wr_bits;

  ////////////////////
  // address decode

  assign sel_mask   = (reg_bus.reg_offset == OFS_INTR_MASK);
  assign sel_set    = (reg_bus.reg_offset == OFS_INTR_SET);
  assign sel_status = (reg_bus.reg_offset == OFS_INTR_STATUS);

  assign wr_mask   = reg_bus.reg_wr_en & sel_mask;
  assign wr_set    = reg_bus.reg_wr_en & sel_set;
  assign wr_status = reg_bus.reg_wr_en & sel_status;

  assign wr_bits = reg_bus.reg_wr_data[NUM_DONE-1:0];  // upper bits dropped

  ////////////////////
  // mask register

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      intr_mask <= '0;  // all sources enabled
    end else if (wr_mask) begin
      intr_mask <= wr_bits;
    end
  end

  assign intr.mask = intr_mask;

  // write-one pulses, applied by the collector at the next edge
  assign intr.sw_set = {NUM_DONE{wr_set}} & wr_bits;
  assign intr.sw_clr = {NUM_DONE{wr_status}} & wr_bits;

  ////////////////////
  // read mux

  always_comb begin
    case (reg_bus.reg_offset)
      OFS_HW_VERSION: begin
        reg_bus.reg_rd_data = HW_VERSION;
      end
      OFS_INTR_MASK: begin
        reg_bus.reg_rd_data = {{(DATA_W-NUM_DONE){1'b0}}, intr_mask};
      end
      OFS_INTR_SET: begin
        reg_bus.reg_rd_data = '0;  // write only
      end
      OFS_INTR_STATUS: begin
        reg_bus.reg_rd_data = {{(DATA_W-NUM_DONE){1'b0}}, intr.status};
      end
      default: begin
        reg_bus.reg_rd_data = '0;  // unmapped
      end
    endcase
  end

  // collector relies on set and clear never arriving together from software
  a_set_clr_excl: assert property (
    @(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    !((|intr.sw_set) && (|intr.sw_clr))
  );

endmodule

// File: source/glb_ic.sv
////////////////////
// interrupt collector, 16 sticky done bits from 8 units x 2 groups
// set beats clear in the same cycle, core_intr lags status by one edge
////////////////////
module glb_ic import glb_pkg::*; (
  input  logic                nvdla_core_clk,
  input  logic                nvdla_core_rstn,
  input  logic [NUM_DONE-1:0] done_pulse,
  glb_intr_if.ic              intr,
  output logic                core_intr
);

  localparam int NUM_UNIT = int'(SRC_CACC) + 1;

  logic [NUM_DONE-1:0] status;
  logic [NUM_DONE-1:0] set_bits;
  logic [NUM_UNIT-1:0] unit_pend;

  ////////////////////
  // sticky status

  assign set_bits = done_pulse | intr.sw_set;

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      status <= '0;
    end else begin
      status <= (status & ~intr.sw_clr) | set_bits;  // set wins
    end
  end

  assign intr.status = status;

  ////////////////////
  // masked interrupt

  // group 0 at bit 2u, group 1 at bit 2u+1
  always_comb begin
    for (int u = 0; u < NUM_UNIT; u++) begin
      unit_pend[u] = |(status[2*u +: 2] & ~intr.mask[2*u +: 2]);
    end
  end

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      core_intr <= 1'b0;
    end else begin
      core_intr <= |unit_pend;
    end
  end

  // a rising interrupt needs an unmasked status bit one edge earlier
  a_intr_needs_unmasked: assert property (
    @(posedge nvdla_core_clk) disable iff (!nvdla_core_rstn)
    $rose(core_intr) |-> $past((intr.status & ~intr.mask) != '0)
  );

endmodule

// File: source/nvdla_glb.sv
////////////////////
// global block top, csb register access and interrupt collection
// request ready is tied high, responses cannot be stalled
////////////////////
module nvdla_glb import glb_pkg::*; #(
  parameter logic [31:0] HW_VERSION = 32'h0001_0001
) (
  input  logic                 nvdla_core_clk,
  input  logic                 nvdla_core_rstn,
  input  logic                 csb2glb_req_pvld,
  input  logic [REQ_PD_W-1:0]  csb2glb_req_pd,
  output logic                 csb2glb_req_prdy,
  output logic                 glb2csb_resp_valid,
  output logic [RESP_PD_W-1:0] glb2csb_resp_pd,
  input  logic [NUM_DONE-1:0]  done_pulse,
  output logic                 core_intr
);

  glb_reg_if  reg_bus ();
  glb_intr_if intr_bus ();

  glb_csb u_csb (
    .nvdla_core_clk     (nvdla_core_clk),
    .nvdla_core_rstn    (nvdla_core_rstn),
    .csb2glb_req_pvld   (csb2glb_req_pvld),
    .csb2glb_req_pd     (csb2glb_req_pd),
    .csb2glb_req_prdy   (csb2glb_req_prdy),
    .glb2csb_resp_valid (glb2csb_resp_valid),
    .glb2csb_resp_pd    (glb2csb_resp_pd),
    .reg_bus            (reg_bus.csb)
  );

  glb_csb_reg #(
    .HW_VERSION (HW_VERSION)
  ) u_reg (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .reg_bus         (reg_bus.regs),
    .intr            (intr_bus.regs)
  );

  glb_ic u_ic (
    .nvdla_core_clk  (nvdla_core_clk),
    .nvdla_core_rstn (nvdla_core_rstn),
    .done_pulse      (done_pulse),
    .intr            (intr_bus.ic),
    .core_intr       (core_intr)
  );

endmodule

// File: verif/tb_nvdla_glb.sv
////////////////////
// global block testbench driving at most one request per cycle
// shadow mask and status predict every response and core_intr
// offsets stay below 0x1000 so no word address aliases
////////////////////
module tb_nvdla_glb import glb_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam logic [31:0] HW_VER = 32'h0002_0103;
  localparam int N_DIRECTED  = 30;   // upper bound of directed cycles
  localparam int N_RAND_DONE = 40;
  localparam int N_B2B       = 100;
  localparam int LIMIT       = 2 * (N_DIRECTED + N_RAND_DONE + N_B2B) + 50;

  logic                 nvdla_core_clk;
  logic                 nvdla_core_rstn;
  logic                 csb2glb_req_pvld;
  logic [REQ_PD_W-1:0]  csb2glb_req_pd;
  logic                 csb2glb_req_prdy;
  logic                 glb2csb_resp_valid;
  logic [RESP_PD_W-1:0] glb2csb_resp_pd;
  logic [NUM_DONE-1:0]  done_pulse;
  logic                 core_intr;

  logic [NUM_DONE-1:0]  sh_mask;     // shadow registers
  logic [NUM_DONE-1:0]  sh_status;
  logic                 pend_wr;     // write captured, lands at next edge
  logic [OFFSET_W-1:0]  pend_ofs;
  logic [DATA_W-1:0]    pend_dat;
  logic                 exp_intr [int];  // by cycle
  int                   due_q [$];       // cycle each response is visible
  logic [RESP_PD_W-1:0] pd_q [$];
  int                   cyc = 0;
  int                   rd_idx = 0;
  int                   mismatch_cnt = 0;
  int                   fail_cnt = 0;

  nvdla_glb #(
    .HW_VERSION (HW_VER)
  ) dut_i (
    .nvdla_core_clk     (nvdla_core_clk),
    .nvdla_core_rstn    (nvdla_core_rstn),
    .csb2glb_req_pvld   (csb2glb_req_pvld),
    .csb2glb_req_pd     (csb2glb_req_pd),
    .csb2glb_req_prdy   (csb2glb_req_prdy),
    .glb2csb_resp_valid (glb2csb_resp_valid),
    .glb2csb_resp_pd    (glb2csb_resp_pd),
    .done_pulse         (done_pulse),
    .core_intr          (core_intr)
  );

  initial begin
    nvdla_core_clk = 1'b0;
    forever #50 nvdla_core_clk = ~nvdla_core_clk;
  end

  ////////////////////
  // reference model

  function automatic logic [RESP_PD_W-1:0] resp_model(input logic wr,
                                                      input logic [OFFSET_W-1:0] ofs);
    logic [DATA_W-1:0] d;
    d = '0;  // set register and unmapped offsets
    if (!wr) begin
      if (ofs == OFS_HW_VERSION) d = HW_VER;
      else if (ofs == OFS_INTR_MASK) d = {16'h0, sh_mask};
      else if (ofs == OFS_INTR_STATUS) d = {16'h0, sh_status};
    end
    return {wr, 1'b0, d};  // kind, error, data
  endfunction

  function automatic logic intr_model(input logic [NUM_DONE-1:0] st,
                                      input logic [NUM_DONE-1:0] mk);
    return |(st & ~mk);
  endfunction

  task automatic check_val(input string what, input logic [RESP_PD_W-1:0] got,
                           input logic [RESP_PD_W-1:0] exp);
    if (got !== exp) begin
      $display("Mismatch at time %0t: %s got 0x%0h expected 0x%0h", $time, what, got, exp);
      mismatch_cnt++;
    end
  endtask

  ////////////////////
  // one stimulus call per clock cycle

  task automatic drive_cycle(input logic vld, input logic wr, input logic np,
                             input logic [OFFSET_W-1:0] ofs, input logic [DATA_W-1:0] wdat,
                             input logic [NUM_DONE-1:0] done);
    logic [NUM_DONE-1:0] set_b;
    logic [NUM_DONE-1:0] clr_b;
    set_b = '0;
    clr_b = '0;
    if (pend_wr && pend_ofs == OFS_INTR_MASK) sh_mask = pend_dat[NUM_DONE-1:0];
    if (pend_wr && pend_ofs == OFS_INTR_SET) set_b = pend_dat[NUM_DONE-1:0];
    if (pend_wr && pend_ofs == OFS_INTR_STATUS) clr_b = pend_dat[NUM_DONE-1:0];
    sh_status = (sh_status & ~clr_b) | set_b | done;  // set wins over clear
    pend_wr  = vld & wr;
    pend_ofs = ofs;
    pend_dat = wdat;
    if (vld && (!wr || np)) begin
      due_q.push_back(cyc + 2);  // captured next edge and registered one later
      pd_q.push_back(resp_model(wr, ofs));
    end
    exp_intr[cyc + 2] = intr_model(sh_status, sh_mask);
    csb2glb_req_pvld = vld;
    csb2glb_req_pd   = {7'($urandom()), np, wr, wdat, {12'h0, ofs[OFFSET_W-1:2]}};
    done_pulse       = done;
    @(posedge nvdla_core_clk);
    #5;
  endtask

  task automatic read_reg(input logic [OFFSET_W-1:0] ofs, input logic [NUM_DONE-1:0] done);
    drive_cycle(1'b1, 1'b0, 1'b0, ofs, '0, done);
  endtask

  task automatic write_reg(input logic [OFFSET_W-1:0] ofs, input logic [DATA_W-1:0] dat,
                           input logic np, input logic [NUM_DONE-1:0] done);
    drive_cycle(1'b1, 1'b1, np, ofs, dat, done);
  endtask

  task automatic idle_cycle(input logic [NUM_DONE-1:0] done);
    drive_cycle(1'b0, 1'b0, 1'b0, '0, '0, done);
  endtask

  initial begin
    int  k;
    logic wr_b;
    logic np_b;
    void'($urandom(31696));
    nvdla_core_rstn  = 1'b0;
    csb2glb_req_pvld = 1'b0;
    csb2glb_req_pd   = '0;
    done_pulse       = '0;
    sh_mask   = '0;
    sh_status = '0;
    pend_wr   = 1'b0;
    pend_ofs  = '0;
    pend_dat  = '0;
    exp_intr[3] = 1'b0;  // first cycles after release
    exp_intr[4] = 1'b0;
    repeat (3) @(posedge nvdla_core_clk);
    #5;
    nvdla_core_rstn = 1'b1;

    read_reg(OFS_HW_VERSION, '0);
    write_reg(OFS_INTR_MASK, 32'hdead_00f0, 1'b1, '0);  // upper half dropped
    read_reg(OFS_INTR_MASK, '0);
    write_reg(OFS_INTR_MASK, 32'h0000_0f0f, 1'b0, '0);  // posted
    read_reg(OFS_INTR_MASK, '0);

    for (int i = 0; i < N_RAND_DONE; i++) begin
      if (i % 4 == 3) read_reg(OFS_INTR_STATUS, 16'($urandom()) & 16'($urandom()));
      else idle_cycle(16'($urandom()) & 16'($urandom()));
    end
    write_reg(OFS_INTR_STATUS, 32'h0000_ffff, 1'b1, '0);
    read_reg(OFS_INTR_STATUS, 16'h0081);  // pulses land on the clearing edge
    read_reg(OFS_INTR_STATUS, '0);

    write_reg(OFS_INTR_SET, 32'h0000_a5a5, 1'b1, '0);
    read_reg(OFS_INTR_SET, '0);
    read_reg(OFS_INTR_STATUS, '0);
    read_reg(12'h010, '0);
    read_reg(12'hffc, '0);
    write_reg(12'h020, 32'hffff_ffff, 1'b1, '0);
    read_reg(12'h020, '0);

    // interrupt masked, cleared, then raised by a fresh pulse
    write_reg(OFS_INTR_MASK, 32'h0000_ffff, 1'b1, '0);
    idle_cycle('0);
    write_reg(OFS_INTR_STATUS, 32'h0000_ffff, 1'b1, '0);
    idle_cycle('0);
    write_reg(OFS_INTR_MASK, 32'h0000_0000, 1'b1, '0);
    idle_cycle(16'h4000);
    idle_cycle('0);
    idle_cycle('0);

    for (int i = 0; i < N_B2B; i++) begin
      k    = $urandom_range(0, 4);
      wr_b = 1'($urandom_range(0, 1));
      np_b = 1'($urandom_range(0, 1));
      drive_cycle(1'b1, wr_b, np_b, (k == 4) ? 12'h010 : 12'(4 * k), $urandom(),
                  16'($urandom()) & 16'($urandom()) & 16'($urandom()));
    end
    repeat (3) idle_cycle('0);  // drain

    $display("summary: %0d mismatches, %0d other errors, %0d of %0d responses seen",
             mismatch_cnt, fail_cnt, rd_idx, due_q.size());
    if (mismatch_cnt == 0 && fail_cnt == 0 && rd_idx == due_q.size()) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

  ////////////////////
  // compare and timeout

  always @(negedge nvdla_core_clk) begin
    check_val("req ready", 34'(csb2glb_req_prdy), 34'd1);
    if (!nvdla_core_rstn) begin
      check_val("resp valid in reset", 34'(glb2csb_resp_valid), 34'd0);
      check_val("core_intr in reset", 34'(core_intr), 34'd0);
    end else begin
      if (exp_intr.exists(cyc)) check_val("core_intr", 34'(core_intr), 34'(exp_intr[cyc]));
      if (glb2csb_resp_valid) begin
        if (rd_idx >= due_q.size()) begin
          $display("Error at time %0t: response arrived with no request pending", $time);
          fail_cnt++;
        end else begin
          if (due_q[rd_idx] != cyc) begin
            $display("Error at time %0t: response due in cycle %0d came in cycle %0d",
                     $time, due_q[rd_idx], cyc);
            fail_cnt++;
          end
          check_val("resp pd", glb2csb_resp_pd, pd_q[rd_idx]);
          rd_idx++;
        end
      end else if (rd_idx < due_q.size() && due_q[rd_idx] <= cyc) begin
        $display("Error at time %0t: expected response missing in cycle %0d", $time, cyc);
        fail_cnt++;
        rd_idx++;
      end
    end
  end

  always @(posedge nvdla_core_clk) begin
    cyc <= cyc + 1;
    if (cyc >= LIMIT) begin
      $display("Error: run still busy after %0d cycles, stopped", LIMIT);
      $display("** FAIL **");
      $finish;
    end
  end

endmodule

// File: nvdla_glb.f
source/glb_pkg.sv
source/glb_reg_if.sv
source/glb_intr_if.sv
source/glb_csb.sv
source/glb_csb_reg.sv
source/glb_ic.sv
source/nvdla_glb.sv
verif/tb_nvdla_glb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the global block testbench with Verilator.
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
  -f nvdla_glb.f \
  --top-module tb_nvdla_glb \
  -o sim_nvdla_glb

./obj_dir/sim_nvdla_glb | tee sim.log

if grep -q '^\*\* PASS \*\*$' sim.log; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed"
  exit 1
fi
